// File: Bender.yml
package:
  name: fb_doubler

export_include_dirs:
  - .

sources:
  - fb_pkg.sv
  - dp_ram.sv
  - fb_regs.sv
  - scanline_fetch.sv
  - scanline_buffer.sv
  - pixel_out.sv
  - fb_doubler.sv
  - target: test
    files:
      - fb_doubler_checker.sv
      - tb_fb_doubler.sv

// File: compile.f
+incdir+.
fb_pkg.sv
dp_ram.sv
fb_regs.sv
scanline_fetch.sv
scanline_buffer.sv
pixel_out.sv
fb_doubler.sv
fb_doubler_checker.sv
tb_fb_doubler.sv

// File: dp_ram.sv
// Simple dual-port RAM
`timescale 1ns/1ps
`include "fb_cfg.svh"

module dp_ram #(
	parameter type data_t = logic [7:0],
	parameter int  DEPTH  = `FB_LINE_DEPTH
) (
	input  logic                     CLK,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  data_t                    wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output data_t                    rdata
);

	data_t mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // Registered read with one cycle latency
	end

endmodule

// File: fb_cfg.svh
// Framebuffer doubler configuration
`ifndef FB_CFG_SVH
`define FB_CFG_SVH

// Datapath widths
`define FB_ADDR_W     16 // Memory word address
`define FB_COORD_W    9  // Source coordinate
`define FB_DISP_W     10 // Display coordinate

// Storage depths
`define FB_LINE_DEPTH 512 // One texel per source column
`define FB_PAL_DEPTH  256

// Register offsets decoded from ADDRESS[3:0]
`define FB_REG_CTRL   4'd0
`define FB_REG_X1     4'd1
`define FB_REG_Y1     4'd2
`define FB_REG_X2     4'd3
`define FB_REG_Y2     4'd4
`define FB_REG_STRIDE 4'd9
`define FB_REG_BASE   4'd10

`endif

// File: fb_doubler.sv
// Pixel-doubling framebuffer overlay
`timescale 1ns/1ps
`include "fb_cfg.svh"

module fb_doubler import fb_pkg::*; (
	input  logic                  CLK,
	input  logic                  RSTb,

	// CPU side
	input  logic [7:0]            ADDRESS,
	input  logic [15:0]           DATA_IN,
	input  logic                  WR_reg,
	input  logic                  WR_pal,

	// Video timing
	input  logic                  H_tick, // Start of display line
	input  logic [`FB_DISP_W-1:0] display_x,
	input  logic [`FB_DISP_W-1:0] display_y,
	output color_t                color,

	// Memory side
	output logic [`FB_ADDR_W-1:0] memory_address,
	input  logic [15:0]           memory_data,
	output logic                  rvalid,
	input  logic                  rready
);

	fb_cfg_t cfg;
	logic    line_we;
	coord_t  line_waddr;
	texel_t  line_wdata;
	coord_t  line_raddr;
	texel_t  line_rdata;

	fb_regs u_regs (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.ADDRESS (ADDRESS),
		.DATA_IN (DATA_IN),
		.WR_reg  (WR_reg),
		.cfg     (cfg)
	);

	scanline_fetch u_fetch (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.H_tick         (H_tick),
		.display_y      (display_y),
		.cfg            (cfg),
		.memory_data    (memory_data),
		.rready         (rready),
		.memory_address (memory_address),
		.rvalid         (rvalid),
		.line_we        (line_we),
		.line_waddr     (line_waddr),
		.line_wdata     (line_wdata)
	);

	scanline_buffer u_buffer (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.H_tick     (H_tick),
		.display_y  (display_y),
		.line_we    (line_we),
		.line_waddr (line_waddr),
		.line_wdata (line_wdata),
		.line_raddr (line_raddr),
		.line_rdata (line_rdata)
	);

	pixel_out u_pixel (
		.CLK        (CLK),
		.ADDRESS    (ADDRESS),
		.DATA_IN    (DATA_IN),
		.WR_pal     (WR_pal),
		.display_x  (display_x),
		.display_y  (display_y),
		.cfg        (cfg),
		.line_raddr (line_raddr),
		.line_rdata (line_rdata),
		.color      (color)
	);

endmodule

// File: fb_doubler_checker.sv
// Fetch and swap protocol checks
`timescale 1ns/1ps
`include "fb_cfg.svh"

module fb_doubler_checker (
	input logic                  CLK,
	input logic                  RSTb,
	input logic                  rvalid,
	input logic                  rready,
	input logic [`FB_ADDR_W-1:0] memory_address,
	input logic                  line_we,
	input logic                  H_tick,
	input logic                  front_bank
);

	int unsigned fail_count = 0; // Failed assertions so far

	// Request held steady until accepted
	a_addr_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		rvalid && !rready |=> rvalid && $stable(memory_address))
		else begin
			$error("memory_address or rvalid changed before rready");
			fail_count++;
		end

	// A texel is written only in the cycle after an accepted request
	a_write_after_xfer: assert property (@(posedge CLK) disable iff (!RSTb)
		line_we |-> !rvalid && $past(rvalid && rready))
		else begin
			$error("line_we without a completed transfer or alongside rvalid");
			fail_count++;
		end

	// Bank flag moves only on the line tick
	a_swap_on_tick: assert property (@(posedge CLK) disable iff (!RSTb)
		$changed(front_bank) |-> $past(H_tick))
		else begin
			$error("front bank toggled without H_tick");
			fail_count++;
		end

endmodule

// File: fb_pkg.sv
// Framebuffer doubler types
`include "fb_cfg.svh"

package fb_pkg;

	// Palette index as stored in memory
	typedef logic [7:0] texel_t;

	// ARGB 4:4:4:4
	typedef logic [15:0] color_t;

	typedef logic [`FB_COORD_W-1:0] coord_t;

	// Register block contents
	typedef struct packed {
		logic        enable;
		coord_t      x1;
		coord_t      x2;
		coord_t      y1;
		coord_t      y2;
		coord_t      stride; // Bytes per source row
		logic [15:0] base;   // Byte address of top-left texel
	} fb_cfg_t;

endpackage

// File: fb_regs.sv
// CPU register block
`timescale 1ns/1ps
`include "fb_cfg.svh"

module fb_regs import fb_pkg::*; (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic [7:0]  ADDRESS,
	input  logic [15:0] DATA_IN,
	input  logic        WR_reg,
	output fb_cfg_t     cfg
);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cfg <= '0;
		end else if (WR_reg) begin
			case (ADDRESS[3:0])
				`FB_REG_CTRL:
					cfg.enable <= DATA_IN[0];
				`FB_REG_X1:
					cfg.x1 <= DATA_IN[`FB_COORD_W-1:0];
				`FB_REG_Y1:
					cfg.y1 <= DATA_IN[`FB_COORD_W-1:0];
				`FB_REG_X2:
					cfg.x2 <= DATA_IN[`FB_COORD_W-1:0]; // Inclusive
				`FB_REG_Y2:
					cfg.y2 <= DATA_IN[`FB_COORD_W-1:0]; // Exclusive
				`FB_REG_STRIDE:
					cfg.stride <= DATA_IN[`FB_COORD_W-1:0];
				`FB_REG_BASE:
					cfg.base <= DATA_IN;
				default: ; // Unmapped offsets ignored
			endcase
		end
	end

endmodule

// File: pixel_out.sv
// Pixel readout and palette lookup
`timescale 1ns/1ps
`include "fb_cfg.svh"

module pixel_out import fb_pkg::*; (
	input  logic                  CLK,
	input  logic [7:0]            ADDRESS,
	input  logic [15:0]           DATA_IN,
	input  logic                  WR_pal,
	input  logic [`FB_DISP_W-1:0] display_x,
	input  logic [`FB_DISP_W-1:0] display_y,
	input  fb_cfg_t               cfg,
	output coord_t                line_raddr,
	input  texel_t                line_rdata,
	output color_t                color
);

	coord_t src_x;
	coord_t src_y;
	logic   hit;
	logic   hit_q1; // Aligned with buffer read
	logic   hit_q2; // Aligned with palette read
	color_t pal_rdata;

	// Each source pixel spans 2x2 display pixels
	assign src_x = display_x[`FB_DISP_W-1:1];
	assign src_y = display_y[`FB_DISP_W-1:1];

	assign line_raddr = src_x;

	assign hit = cfg.enable &&
		(src_y >= cfg.y1) && (src_y < cfg.y2) &&
		(src_x >= cfg.x1) && (src_x <= cfg.x2);

	always_ff @(posedge CLK) begin
		hit_q1 <= hit;
		hit_q2 <= hit_q1;
	end

	dp_ram #(
		.data_t (color_t),
		.DEPTH  (`FB_PAL_DEPTH)
	) u_palette (
		.CLK   (CLK),
		.we    (WR_pal),
		.waddr (ADDRESS),
		.wdata (DATA_IN),
		.raddr (line_rdata), // Texel indexes the palette directly
		.rdata (pal_rdata)
	);

	assign color = hit_q2 ? pal_rdata : '0; // Outside window is transparent black

endmodule

// File: scanline_buffer.sv
// Ping-pong scanline buffer
`timescale 1ns/1ps
`include "fb_cfg.svh"

module scanline_buffer import fb_pkg::*; (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  logic                  H_tick,
	input  logic [`FB_DISP_W-1:0] display_y,
	input  logic                  line_we,
	input  coord_t                line_waddr,
	input  texel_t                line_wdata,
	input  coord_t                line_raddr,
	output texel_t                line_rdata
);

	logic   front_bank; // Bank read by the display
	logic   swap;
	logic   rd_front;
	logic   rd_bank_q;
	texel_t bank_rdata [2];

	// Swap at the first line of each pair
	assign swap = H_tick && !display_y[0];

	// Reads in the swap cycle already see the new front bank
	assign rd_front = front_bank ^ swap;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			front_bank <= 1'b0;
		else if (swap)
			front_bank <= ~front_bank;
	end

	// Which bank the registered read data came from
	always_ff @(posedge CLK) begin
		rd_bank_q <= rd_front;
	end

	for (genvar i = 0; i < 2; i++) begin : g_bank
		dp_ram #(
			.data_t (texel_t),
			.DEPTH  (`FB_LINE_DEPTH)
		) u_ram (
			.CLK   (CLK),
			.we    (line_we && (front_bank != 1'(i))), // Back bank only
			.waddr (line_waddr),
			.wdata (line_wdata),
			.raddr (line_raddr),
			.rdata (bank_rdata[i])
		);
	end

	assign line_rdata = bank_rdata[rd_bank_q];

endmodule

// File: scanline_fetch.sv
// Scanline fetch engine
`timescale 1ns/1ps
`include "fb_cfg.svh"

module scanline_fetch import fb_pkg::*; (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  logic                  H_tick,
	input  logic [`FB_DISP_W-1:0] display_y,
	input  fb_cfg_t               cfg,
	input  logic [15:0]           memory_data,
	input  logic                  rready,
	output logic [`FB_ADDR_W-1:0] memory_address,
	output logic                  rvalid,
	output logic                  line_we,
	output coord_t                line_waddr,
	output texel_t                line_wdata
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH, // Request held until rready
		ST_WRITE  // Texel into back bank
	} state_t;

	state_t state;

	logic [`FB_COORD_W:0]   next_row; // Source row for the coming line pair
	logic [`FB_COORD_W:0]   row_rel;
	logic [2*`FB_COORD_W:0] row_off;
	logic [`FB_ADDR_W:0]    row_start;
	logic [`FB_ADDR_W:0]    byte_addr; // Byte address one bit wider than the word address
	coord_t                 col;
	texel_t                 texel;
	logic                   start;

	assign next_row = {1'b0, display_y[`FB_DISP_W-1:1]} + 1'b1;

	// Kick off on the swap tick when the next row lies in the window
	assign start = H_tick && !display_y[0] && cfg.enable &&
		(next_row >= {1'b0, cfg.y1}) && (next_row < {1'b0, cfg.y2});

	// Row start = base + (row - y1) * stride
	assign row_rel   = next_row - {1'b0, cfg.y1};
	assign row_off   = row_rel * cfg.stride;
	assign row_start = {1'b0, cfg.base} + row_off[`FB_ADDR_W:0];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start)
						state <= ST_FETCH;
				end
				ST_FETCH: begin
					if (rready)
						state <= ST_WRITE;
				end
				ST_WRITE: begin
					if (col == cfg.x2)
						state <= ST_IDLE; // Row complete
					else
						state <= ST_FETCH;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Address and texel registers
	always_ff @(posedge CLK) begin
		case (state)
			ST_IDLE: begin
				if (start) begin
					byte_addr <= row_start;
					col       <= cfg.x1;
				end
			end
			ST_FETCH: begin
				if (rready)
					texel <= byte_addr[0] ? memory_data[15:8] : memory_data[7:0];
			end
			ST_WRITE: begin
				col       <= col + 1'b1;
				byte_addr <= byte_addr + 1'b1;
			end
			default: ;
		endcase
	end

	assign memory_address = byte_addr[`FB_ADDR_W:1]; // Steady through the request
	assign rvalid         = (state == ST_FETCH);
	assign line_we        = (state == ST_WRITE);
	assign line_waddr     = col; // Buffer indexed by source column
	assign line_wdata     = texel;

endmodule

// File: tb_fb_doubler.sv
// Framebuffer doubler testbench
`timescale 1ns/1ps
`include "fb_cfg.svh"

module tb_fb_doubler import fb_pkg::*; ();

	localparam int LINE_LEN    = 160;
	localparam int FRAME_LINES = 24;
	localparam int N_FRAMES    = 5;
	localparam int MEM_WORDS   = 2048;
	localparam int TIMEOUT_NS  = (N_FRAMES * FRAME_LINES * LINE_LEN + 1500) * 10 * 2;

	logic                  CLK = 1'b0;
	logic                  RSTb;
	logic [7:0]            ADDRESS;
	logic [15:0]           DATA_IN;
	logic                  WR_reg;
	logic                  WR_pal;
	logic                  H_tick;
	logic [`FB_DISP_W-1:0] display_x;
	logic [`FB_DISP_W-1:0] display_y;
	color_t                color;
	logic [`FB_ADDR_W-1:0] memory_address;
	logic [15:0]           memory_data;
	logic                  rvalid;
	logic                  rready;

	logic [15:0] lfsr;
	logic [15:0] bp_lfsr; // Own stream for the memory model
	logic [15:0] mem_words [MEM_WORDS];
	color_t      pal [256];
	int          m_en, m_x1, m_x2, m_y1, m_y2, m_stride, m_base; // Register mirror
	color_t      pipe_exp [2];
	bit          pipe_v [2];
	bit          bp_on, fetch_allowed, armed;
	int          delay;
	string       test_name;

	fb_doubler u_dut (.*);

	always #5 CLK = ~CLK;

	initial begin
		#(TIMEOUT_NS);
		abort_run("watchdog expired before all frames were shown");
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic int rand_bits(input int n);
		int v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	task automatic abort_run(input string msg);
		$display("Error: %s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic show_mismatch(input string name, input logic [15:0] exp, input logic [15:0] act);
		$display("** Error %s: expected %h, actual %h", name, exp, act);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	// Colour from the 2x2 mapping and the window address formula
	function automatic color_t expected_color(input int dx, input int dy);
		int          c;
		int          r;
		int          a;
		logic [15:0] w;
		c = dx / 2;
		r = dy / 2;
		if (!m_en || r < m_y1 || r >= m_y2 || c < m_x1 || c > m_x2)
			return '0;
		a = m_base + (r - m_y1) * m_stride + (c - m_x1);
		w = mem_words[a / 2];
		return pal[(a % 2) ? w[15:8] : w[7:0]]; // Odd byte address takes the high byte
	endfunction

	// Memory model answering a request after 0..3 idle cycles when back-pressure is on
	always @(negedge CLK) begin
		if (!rvalid) begin
			rready = 1'b0;
			armed  = 1'b0;
		end else begin
			if (!armed) begin
				delay = 0;
				repeat (2) begin
					delay   = (delay << 1) | bp_lfsr[0];
					bp_lfsr = lfsr_next(bp_lfsr);
				end
				if (!bp_on)
					delay = 0;
				armed = 1'b1;
			end
			if (delay == 0) begin
				assert (memory_address < MEM_WORDS)
					else abort_run("memory request outside the modelled memory");
				memory_data = mem_words[memory_address];
				rready      = 1'b1;
			end else begin
				delay--;
			end
		end
	end

	task automatic write_reg(input logic [3:0] off, input int val);
		@(negedge CLK);
		ADDRESS = {4'h0, off};
		DATA_IN = val[15:0];
		WR_reg  = 1'b1;
		case (off)
			`FB_REG_CTRL:   m_en = val & 1;
			`FB_REG_X1:     m_x1 = val % 512;
			`FB_REG_Y1:     m_y1 = val % 512;
			`FB_REG_X2:     m_x2 = val % 512;
			`FB_REG_Y2:     m_y2 = val % 512;
			`FB_REG_STRIDE: m_stride = val % 512;
			`FB_REG_BASE:   m_base = val % 65536;
			default: ;
		endcase
		@(negedge CLK);
		WR_reg = 1'b0;
	endtask

	task automatic write_pal(input int idx, input int val);
		@(negedge CLK);
		ADDRESS = idx[7:0];
		DATA_IN = val[15:0];
		WR_pal  = 1'b1;
		pal[idx] = val[15:0];
		@(negedge CLK);
		WR_pal = 1'b0;
	endtask

	// Window kept below row 12 so no fetch spills into the next frame
	task automatic program_window();
		int x1;
		int w;
		int y1;
		int h;
		int pad;
		int base;
		x1   = 2 + rand_bits(4);
		w    = 8 + rand_bits(5);
		y1   = 1 + rand_bits(2);
		h    = 3 + rand_bits(2);
		pad  = rand_bits(6);
		base = rand_bits(11);
		write_reg(`FB_REG_X1, x1);
		write_reg(`FB_REG_X2, x1 + w - 1);
		write_reg(`FB_REG_Y1, y1);
		write_reg(`FB_REG_Y2, y1 + h);
		write_reg(`FB_REG_STRIDE, w + pad);
		write_reg(`FB_REG_BASE, base);
		write_reg(`FB_REG_CTRL, 1);
	endtask

	// One display pixel; color is checked two cycles after its coordinates
	task automatic video_cycle(input int dx, input int dy, input bit valid);
		@(negedge CLK);
		if (pipe_v[1])
			assert (color === pipe_exp[1]) else show_mismatch(test_name, pipe_exp[1], color);
		assert (!rvalid || fetch_allowed)
			else abort_run("rvalid raised for a row outside the window");
		assert (u_dut.u_checker.fail_count == 0) else abort_run("a bound protocol assertion failed");
		pipe_v[1]   = pipe_v[0];
		pipe_exp[1] = pipe_exp[0];
		pipe_v[0]   = valid;
		pipe_exp[0] = expected_color(dx, dy);
		H_tick      = valid && (dx == 0);
		display_x   = dx;
		display_y   = dy;
		if (H_tick && (dy % 2 == 0))
			fetch_allowed = m_en && (dy / 2 + 1 >= m_y1) && (dy / 2 + 1 < m_y2);
	endtask

	task automatic run_frame(input string name);
		test_name = name;
		for (int y = 0; y < FRAME_LINES; y++)
			for (int x = 0; x < LINE_LEN; x++)
				video_cycle(x, y, 1'b1);
		repeat (2) video_cycle(0, 0, 1'b0); // Drain the readout pipeline
	endtask

	initial begin
		int idx;
		int val;
		RSTb = 1'b0;
		ADDRESS = '0;
		DATA_IN = '0;
		WR_reg = 1'b0;
		WR_pal = 1'b0;
		H_tick = 1'b0;
		display_x = '0;
		display_y = '0;
		memory_data = '0;
		rready = 1'b0;
		lfsr = 16'd23434;
		bp_lfsr = 16'd23434;
		{m_en, m_x1, m_x2, m_y1, m_y2, m_stride, m_base} = '0;
		pipe_v = '{default: 1'b0};
		for (int i = 0; i < MEM_WORDS; i++)
			mem_words[i] = rand_bits(16);
		repeat (3) @(negedge CLK);
		RSTb = 1'b1;

		run_frame("idle_frame"); // Enable still clear

		for (int i = 0; i < 256; i++) begin
			val = rand_bits(16);
			write_pal(i, val);
		end
		program_window();
		run_frame("window");

		// Same window, palette and memory as the zero-delay frame
		bp_on = 1'b1;
		run_frame("backpressure");

		program_window();
		repeat (16) begin
			idx = rand_bits(8);
			val = rand_bits(16);
			write_pal(idx, val);
		end
		run_frame("reprogram");
		program_window();
		run_frame("reprogram_again");

		if (u_dut.u_checker.fail_count == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			abort_run("a bound protocol assertion failed");
		end
	end

endmodule

bind fb_doubler fb_doubler_checker u_checker (
	.CLK            (CLK),
	.RSTb           (RSTb),
	.rvalid         (rvalid),
	.rready         (rready),
	.memory_address (memory_address),
	.line_we        (line_we),
	.H_tick         (H_tick),
	.front_bank     (u_buffer.front_bank)
);
